// ==== logic/bin_count_table.sv ====
`default_nettype none

module bin_count_table (
  input  logic                         clkb,    // Clock
  input  logic                         rstb,    // Clears the whole table
  input  binned_mem_pkg::count_wr_t    cnt_wr,  // One count load per cycle
  output binned_mem_pkg::count_table_t counts   // All 64 counts
);

  import binned_mem_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  logic [NUM_PAGES-1:0]               page_hit;  // One-hot page select
  logic [NUM_BINS-1:0]                bin_hit;   // One-hot bin select
  logic [NUM_PAGES-1:0][NUM_BINS-1:0] load_sel;  // One-hot count select

  // Strobe folded into the page decode
  always_comb begin
    page_hit               = '0;
    page_hit[cnt_wr.page]  = cnt_wr.en;  // Nothing selected without a load
  end

  always_comb begin
    bin_hit              = '0;
    bin_hit[cnt_wr.bin]  = 1'b1;  // Bin of the load
  end

  // Cross product of the two decodes
  generate
    for (genvar p = 0; p < NUM_PAGES; p++) begin : g_page
      for (genvar b = 0; b < NUM_BINS; b++) begin : g_bin
        assign load_sel[p][b] = page_hit[p] & bin_hit[b];  // At most one set
      end
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // Count registers
  //////////////////////////////////////////////////////////////////////

  count_table_t count_q;  // Page by bin

  always_ff @(posedge clkb) begin
    if (rstb) begin
      count_q <= '0;  // Every bin empty
    end else begin
      for (int p = 0; p < NUM_PAGES; p++) begin
        for (int b = 0; b < NUM_BINS; b++) begin
          if (load_sel[p][b]) begin
            count_q[p][b] <= cnt_wr.count;  // Replace, no accumulate
          end
        end
      end
    end
  end

  assign counts = count_q;  // Full table, one cycle after the load

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // An unknown page or bin would smear the load over several counts
  a_load_index_known : assert property (
    @(posedge clkb) disable iff (rstb)
    cnt_wr.en |-> !$isunknown({cnt_wr.page, cnt_wr.bin})
  ) else $error("bin_count_table: load enabled with unknown page or bin");

endmodule : bin_count_table

`default_nettype wire

// ==== logic/binned_mem_pkg.sv ====
`default_nettype none

package binned_mem_pkg;

  //////////////////////////////////////////////////////////////////////
  // Geometry of the binned store
  //////////////////////////////////////////////////////////////////////

  localparam int PAGE_BITS  = 3;   // 8 pages
  localparam int BIN_BITS   = 3;   // 8 bins per page
  localparam int ENTRY_BITS = 4;   // 16 entries per bin, also count width
  localparam int STUB_WIDTH = 14;  // Default stub word width

  localparam int NUM_PAGES  = 1 << PAGE_BITS;  // Pages in the store
  localparam int NUM_BINS   = 1 << BIN_BITS;   // Bins in one page
  localparam int ADDR_BITS  = PAGE_BITS + BIN_BITS + ENTRY_BITS;  // 10 bits
  localparam int MEM_DEPTH  = 1 << ADDR_BITS;  // 1024 words

  //////////////////////////////////////////////////////////////////////
  // Index and payload types
  //////////////////////////////////////////////////////////////////////

  typedef logic [PAGE_BITS-1:0]  page_t;   // Page index
  typedef logic [BIN_BITS-1:0]   bin_t;    // Bin index within a page
  typedef logic [ENTRY_BITS-1:0] entry_t;  // Entry index within a bin

  // Page in the top bits, entry in the bottom bits
  typedef struct packed {
    page_t  page;   // Selects one of 8 pages
    bin_t   bin;    // Selects one of 8 bins
    entry_t entry;  // Selects one of 16 entries
  } stub_addr_t;

  typedef logic [STUB_WIDTH-1:0] stub_word_t;  // One stored stub

  typedef logic [ENTRY_BITS-1:0] bin_count_t;  // Entries held in one bin

  // Bin 0 in the low nibble
  typedef bin_count_t [NUM_BINS-1:0] page_counts_t;  // 32 bits per page

  // Page 0 in the low word
  typedef page_counts_t [NUM_PAGES-1:0] count_table_t;  // 256 bits in all

  //////////////////////////////////////////////////////////////////////
  // Request bundles
  //////////////////////////////////////////////////////////////////////

  // Single-cycle write strobe with its address and data
  typedef struct packed {
    logic       en;    // Write strobe
    stub_addr_t addr;  // Target page, bin and entry
    stub_word_t data;  // Word to store
  } stub_wr_t;

  // Load of one bin count
  typedef struct packed {
    logic       en;     // Load strobe
    page_t      page;   // Page of the count
    bin_t       bin;    // Bin of the count
    bin_count_t count;  // New entry count
  } count_wr_t;

  // Read latency choice of the store
  typedef enum logic {
    LAT_LOW_LATENCY = 1'b0,  // 1 cycle, data straight from the staging register
    LAT_HIGH_PERF   = 1'b1   // 2 cycles, extra output register
  } ram_latency_e;

endpackage : binned_mem_pkg

`default_nettype wire

// ==== logic/binned_memory.sv ====
`default_nettype none

module binned_memory #(
  parameter binned_mem_pkg::ram_latency_e LATENCY = binned_mem_pkg::LAT_HIGH_PERF
) (
  input  logic                         clkb,     // Clock for the whole block
  input  logic                         rstb,     // Sync reset, active high
  input  binned_mem_pkg::stub_wr_t     wr,       // Stub write strobe
  input  logic                         rd_en,    // Stub read enable
  input  binned_mem_pkg::stub_addr_t   rd_addr,  // Stub read address
  input  logic                         regceb,   // Output register enable
  input  binned_mem_pkg::count_wr_t    cnt_wr,   // Bin count load
  output binned_mem_pkg::stub_word_t   doutb,    // Stub read data
  output binned_mem_pkg::count_table_t counts    // Entry counts of all bins
);

  //////////////////////////////////////////////////////////////////////
  // Stub store
  //////////////////////////////////////////////////////////////////////

  stub_ram #(
    .LATENCY (LATENCY)   // Latency fixed here for the subtree
  ) u_stub_ram (
    .clkb    (clkb),
    .rstb    (rstb),     // Output register only
    .wr      (wr),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .regceb  (regceb),
    .doutb   (doutb)
  );

  //////////////////////////////////////////////////////////////////////
  // Entry count table
  //////////////////////////////////////////////////////////////////////

  bin_count_table u_bin_count_table (
    .clkb   (clkb),
    .rstb   (rstb),      // Clears every count
    .cnt_wr (cnt_wr),
    .counts (counts)
  );

endmodule : binned_memory

`default_nettype wire

// ==== logic/stub_ram.sv ====
`default_nettype none

module stub_ram #(
  parameter binned_mem_pkg::ram_latency_e LATENCY = binned_mem_pkg::LAT_HIGH_PERF
) (
  input  logic                       clkb,     // Single clock for both ports
  input  logic                       rstb,     // Clears the output register only
  input  binned_mem_pkg::stub_wr_t   wr,       // Write strobe, address, data
  input  logic                       rd_en,    // Read enable
  input  binned_mem_pkg::stub_addr_t rd_addr,  // Read address
  input  logic                       regceb,   // Output register enable
  output binned_mem_pkg::stub_word_t doutb     // Read data
);

  import binned_mem_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // Block-style array, starts at zero like the hardware does
  stub_word_t mem [MEM_DEPTH] = '{default: '0};

  // Staging register behind the array read port
  stub_word_t ram_data = '0;

  // Flat indices into the array
  logic [ADDR_BITS-1:0] wr_index;  // Write side
  logic [ADDR_BITS-1:0] rd_index;  // Read side

  assign wr_index = wr.addr;  // Page, bin, entry concatenated
  assign rd_index = rd_addr;  // Same layout

  //////////////////////////////////////////////////////////////////////
  // Write port and read port
  //////////////////////////////////////////////////////////////////////

  // Write lands at the same edge
  always_ff @(posedge clkb) begin
    if (wr.en) begin
      mem[wr_index] <= wr.data;  // Store the stub
    end
  end

  // Nonblocking read sees the old word on a collision, so read-first
  always_ff @(posedge clkb) begin
    if (rd_en) begin
      ram_data <= mem[rd_index];  // Stage the word
    end                           // Otherwise hold the last word
  end

  //////////////////////////////////////////////////////////////////////
  // Output stage
  //////////////////////////////////////////////////////////////////////

  generate
    if (LATENCY == LAT_LOW_LATENCY) begin : g_low_latency

      // One cycle, longer clock-to-out
      assign doutb = ram_data;

    end else begin : g_high_perf

      stub_word_t dout_q;  // Output register

      // Second cycle of the pipeline, gated by regceb
      always_ff @(posedge clkb) begin
        if (rstb) begin
          dout_q <= '0;  // Output clears, array and staging untouched
        end else if (regceb) begin
          dout_q <= ram_data;  // Take the staged word
        end                    // regceb low, hold
      end

      assign doutb = dout_q;

      // regceb decides what the register takes, so it must be driven
      a_regceb_known : assert property (
        @(posedge clkb) disable iff (rstb)
        !$isunknown(regceb)
      ) else $error("stub_ram: regceb unknown in high performance mode");

    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // An unknown write address would corrupt an unknown word
  a_wr_addr_known : assert property (
    @(posedge clkb) disable iff (rstb)
    wr.en |-> !$isunknown(wr.addr)
  ) else $error("stub_ram: write enabled with unknown address");

endmodule : stub_ram

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the binned memory testbench with Verilator
verilator --binary --timing --assert --timescale 1ns/1ns -f sources.f \
  --top-module binned_memory_tb -o sim_binned_memory || exit 1
sim_out=$(./obj_dir/sim_binned_memory)
echo "$sim_out"
echo "$sim_out" | grep -qx "TB PASSED" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== sources.f ====
+incdir+include
logic/binned_mem_pkg.sv
logic/stub_ram.sv
logic/bin_count_table.sv
logic/binned_memory.sv
verification/binned_memory_tb.sv

// ==== include/binned_memory_checks.svh ====
`ifndef BINNED_MEMORY_CHECKS_SVH
`define BINNED_MEMORY_CHECKS_SVH

// Included inside the testbench module, after the package import

int error_count = 0;  // Mismatches seen so far

stub_word_t   shadow_mem [MEM_DEPTH] = '{default: '0};  // Mirror of the store
count_table_t shadow_counts = '0;                       // Mirror of the table

logic [31:0] xs_state = 32'ha4b4fefc;  // Xorshift seed

// 32-bit xorshift, advances the shared state
function automatic logic [31:0] xorshift();
  logic [31:0] x;
  x        = xs_state;
  x        = x ^ (x << 13);
  x        = x ^ (x >> 17);
  x        = x ^ (x << 5);
  xs_state = x;
  return x;
endfunction

// Random page, bin and entry
function automatic stub_addr_t rand_addr();
  logic [31:0] r;
  r = xorshift();
  return stub_addr_t'(r[ADDR_BITS-1:0]);
endfunction

// Word compare, one ERROR line per miss
task automatic check_word(input string what, input stub_word_t got, input stub_word_t exp);
  if (got !== exp) begin
    error_count++;
    $display("ERROR %0t: %s read %h, expected %h", $time, what, got, exp);
  end
endtask

// Table compare, reports every bin that differs
task automatic check_count_table(input string what, input count_table_t got,
                                 input count_table_t exp);
  for (int p = 0; p < NUM_PAGES; p++) begin
    for (int b = 0; b < NUM_BINS; b++) begin
      if (got[p][b] !== exp[p][b]) begin
        error_count++;
        $display("ERROR %0t: %s page %0d bin %0d count %h, expected %h",
                 $time, what, p, b, got[p][b], exp[p][b]);
      end
    end
  end
endtask

// Reference models
task automatic model_write(input stub_addr_t addr, input stub_word_t data);
  shadow_mem[addr] = data;  // Same edge as the DUT
endtask

function automatic stub_word_t model_read(input stub_addr_t addr);
  return shadow_mem[addr];
endfunction

task automatic model_load(input count_wr_t c);
  if (c.en) begin
    shadow_counts[c.page][c.bin] = c.count;  // Only the addressed bin
  end
endtask

task automatic model_clear_counts();
  shadow_counts = '0;  // Table reset, store untouched
endtask

`endif

// ==== verification/binned_memory_tb.sv ====
`default_nettype none

module binned_memory_tb;

  timeunit 1ns;
  timeprecision 1ns;

  import binned_mem_pkg::*;

  localparam int NUM_WRITES     = 32;   // Random stub writes
  localparam int NUM_LOADS      = 48;   // Random count loads
  localparam int TEST_CYCLES    = 500;  // All tests together, rounded up
  localparam int TIMEOUT_CYCLES = 6 * TEST_CYCLES;  // About 3000

  logic         clkb;
  logic         rstb;
  stub_wr_t     wr;
  logic         rd_en;
  stub_addr_t   rd_addr;
  logic         regceb;
  count_wr_t    cnt_wr;
  stub_word_t   doutb;
  count_table_t counts;

  `include "binned_memory_checks.svh"

  stub_addr_t written_q [$];        // Every address stored so far
  bit         written [MEM_DEPTH];  // Set once an address holds a word
  int         cycle_count = 0;      // Posedges since time zero

  binned_memory #(
    .LATENCY (LAT_HIGH_PERF)  // Two-cycle read path with output register
  ) uut (
    .clkb    (clkb),
    .rstb    (rstb),
    .wr      (wr),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .regceb  (regceb),
    .cnt_wr  (cnt_wr),
    .doutb   (doutb),
    .counts  (counts)
  );

  ////////////////////////////////////////////////////////////////////
  // Clock and timeout
  ////////////////////////////////////////////////////////////////////

  initial begin
    clkb = 1'b0;
    forever #50 clkb = ~clkb;  // 100 ns period
  end

  always @(posedge clkb) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus helpers, all driven on the falling edge
  ////////////////////////////////////////////////////////////////////

  function automatic stub_word_t rand_word();
    logic [31:0] r;
    r = xorshift();
    return r[STUB_WIDTH-1:0];  // Low bits of the draw
  endfunction

  // One write strobe, mirrored in the shadow array
  task automatic write_word(input stub_addr_t addr, input stub_word_t data);
    @(negedge clkb);
    wr.en   = 1'b1;
    wr.addr = addr;
    wr.data = data;
    model_write(addr, data);
    written[addr] = 1'b1;
    written_q.push_back(addr);
    @(negedge clkb);
    wr.en = 1'b0;  // Single-cycle strobe
  endtask

  // Read with regceb high, word shows two edges later
  task automatic read_word(input stub_addr_t addr, output stub_word_t data);
    @(negedge clkb);
    rd_en   = 1'b1;
    rd_addr = addr;
    regceb  = 1'b1;
    @(negedge clkb);  // Staged
    rd_en = 1'b0;
    @(negedge clkb);  // In the output register
    data = doutb;
  endtask

  // One count load, table checked one cycle later
  task automatic load_count(input page_t page, input bin_t bin, input bin_count_t count);
    @(negedge clkb);
    cnt_wr.en    = 1'b1;
    cnt_wr.page  = page;
    cnt_wr.bin   = bin;
    cnt_wr.count = count;
    model_load(cnt_wr);
    @(negedge clkb);
    cnt_wr.en = 1'b0;
    check_count_table("count load", counts, shadow_counts);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////

  task automatic verify_reset_outputs();
    check_word("doutb after reset", doutb, '0);
    check_count_table("counts after reset", counts, '0);
  endtask

  task automatic write_then_read_back();
    stub_addr_t a;
    stub_word_t got;
    bit         found;
    for (int k = 0; k < 4; k++) begin  // First and last entry of spread bins
      a.page  = page_t'(k * 3);
      a.bin   = bin_t'(k * 5);
      a.entry = '0;
      write_word(a, rand_word());
      a.entry = '1;
      write_word(a, rand_word());
    end
    for (int i = 0; i < NUM_WRITES; i++) begin
      write_word(rand_addr(), rand_word());
    end
    foreach (written_q[i]) begin
      read_word(written_q[i], got);
      check_word("readback", got, model_read(written_q[i]));
    end
    found = 1'b0;
    for (int i = 0; i < MEM_DEPTH && !found; i++) begin
      if (!written[i]) begin
        a     = stub_addr_t'(i[ADDR_BITS-1:0]);  // First address never written
        found = 1'b1;
      end
    end
    if (found) begin
      read_word(a, got);
      check_word("never written", got, '0);
    end else begin
      $display("Every address was written, so no unwritten address could be read");
      error_count++;
    end
  endtask

  task automatic hold_with_regceb_low();
    stub_addr_t a;
    stub_addr_t b;
    stub_word_t got;
    a = '{page: 3'd2, bin: 3'd4, entry: 4'd9};
    b = '{page: 3'd6, bin: 3'd1, entry: 4'd3};
    write_word(a, 14'h1555);
    write_word(b, 14'h2aaa);  // Differs from a in every bit
    read_word(a, got);
    check_word("word before hold", got, model_read(a));
    @(negedge clkb);
    rd_en   = 1'b1;
    rd_addr = b;
    regceb  = 1'b0;  // Stage b, keep a on the output
    @(negedge clkb);
    rd_en = 1'b0;
    repeat (3) begin
      @(negedge clkb);
      check_word("regceb low", doutb, model_read(a));
    end
    regceb = 1'b1;  // Staged word unchanged
    @(negedge clkb);
    check_word("regceb raised", doutb, model_read(b));
  endtask

  task automatic collide_read_and_write();
    stub_addr_t a;
    stub_word_t old_word;
    stub_word_t new_word;
    a        = rand_addr();
    old_word = model_read(a);  // Before the shadow sees the write
    new_word = ~old_word;
    @(negedge clkb);
    wr.en   = 1'b1;
    wr.addr = a;
    wr.data = new_word;
    rd_en   = 1'b1;
    rd_addr = a;
    regceb  = 1'b1;
    model_write(a, new_word);
    written[a] = 1'b1;
    written_q.push_back(a);
    @(negedge clkb);
    wr.en = 1'b0;  // Read stays on, same address one cycle later
    @(negedge clkb);
    rd_en = 1'b0;
    check_word("read at write edge", doutb, old_word);
    @(negedge clkb);
    check_word("read after write", doutb, new_word);
  endtask

  task automatic load_and_clear_counts();
    logic [31:0] r;
    stub_word_t  got;
    for (int i = 0; i < NUM_LOADS; i++) begin
      r = xorshift();
      load_count(page_t'(r[2:0]), bin_t'(r[5:3]), bin_count_t'(r[11:8]));
    end
    @(negedge clkb);
    rstb = 1'b1;
    @(negedge clkb);
    rstb = 1'b0;
    model_clear_counts();
    check_count_table("counts after rstb", counts, shadow_counts);
    check_word("doutb after rstb", doutb, '0);
    foreach (written_q[i]) begin  // Store survives the reset
      read_word(written_q[i], got);
      check_word("readback after rstb", got, model_read(written_q[i]));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Sequence and closing report
  ////////////////////////////////////////////////////////////////////

  initial begin
    rstb    = 1'b1;
    wr      = '0;
    rd_en   = 1'b0;
    rd_addr = '0;
    regceb  = 1'b0;
    cnt_wr  = '0;
    repeat (4) @(negedge clkb);  // Four reset edges
    rstb = 1'b0;
    verify_reset_outputs();
    write_then_read_back();
    hold_with_regceb_low();
    collide_read_and_write();
    load_and_clear_counts();
    repeat (2) @(negedge clkb);
    $display("Closing report: %0d errors", error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : binned_memory_tb

`default_nettype wire
